// ==== bench/bpu_tb.sv ====
`timescale 1ns/1ps

module bpu_tb
    import bpu_pkg::*;
;

    localparam int          NROWS    = 64;
    localparam logic [31:0] LCG_SEED = 32'h311d_0724;
    localparam logic [31:0] JMP_PC   = 32'h1c03_4564;   // slot 1
    localparam logic [31:0] JMP_TGT  = 32'h1c05_0000;
    localparam logic [31:0] CND_PC   = 32'h1c00_4a10;   // slot 0
    localparam logic [31:0] CND_TGT  = 32'h1c00_6000;
    localparam logic [31:0] CALL_PC  = 32'h1c00_8000;
    localparam logic [31:0] RET_PC   = 32'h1c00_9104;   // slot 1
    localparam logic [31:0] SEL_PC   = 32'h1c00_c000;

    // one stimulus row with its expected response
    typedef struct packed {
        logic          flush;
        logic [31:0]   redir;
        logic          ready;
        correct_info_t ci0;
        correct_info_t ci1;
        logic [31:0]   exp_pc;
        logic [1:0]    exp_mask;
        slot_predict_t exp_pred0;
        slot_predict_t exp_pred1;
        logic [31:0]   exp_next;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                flush_i;
    logic                ready_i;
    logic [31:0]         redir_addr_i;
    correct_info_t [1:0] correct_infos_i;
    fetch_pkg_t          fetch_o;

    row_t        rows [NROWS];
    int          nrows;
    logic [31:0] lcg_state;

    // reference model state
    logic [31:0]    m_pc;
    bpu_btb_entry_t m_btb [2][64];
    logic [4:0]     m_bht [2][64];
    logic [1:0]     m_pht [2][256];
    logic [31:0]    m_ras [$];

    bpu UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .ready_i         (ready_i),
        .redir_addr_i    (redir_addr_i),
        .correct_infos_i (correct_infos_i),
        .fetch_o         (fetch_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run length bounded by table size plus reset margin
    initial begin
        #((NROWS + 20) * 100);
        $display("watchdog expired before the stimulus table finished");
        $display("TEST FAIL");
        $fatal(1);
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [5:0] ref_idx(input logic [31:0] pc);
        return pc[14:9] ^ pc[8:3];   // folded index
    endfunction

    function automatic logic [7:0] ref_tag(input logic [31:0] pc);
        return pc[19:12];
    endfunction

    function automatic logic [1:0] ref_count(input logic [1:0] c, input logic t);
        if (t) begin
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        end
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    function automatic logic [31:0] ras_peek();
        return (m_ras.size() == 0) ? 32'd0 : m_ras[$];   // empty reads zero
    endfunction

    // what slot s should report at the model pc
    function automatic slot_predict_t ref_predict(input int s);
        slot_predict_t  p;
        bpu_btb_entry_t e;
        logic [5:0]     i;
        logic [4:0]     h;
        logic [1:0]     c;
        i = ref_idx(m_pc);
        e = m_btb[s][i];
        h = m_bht[s][i];
        c = m_pht[s][{h, m_pc[5:3]}];
        p.hit       = e.is_branch && (e.tag == ref_tag(m_pc));
        p.is_branch = e.is_branch;
        p.br_type   = e.br_type;
        p.target_pc = (p.hit && e.br_type == BR_RET) ? ras_peek() : e.target_pc;
        p.taken     = p.hit && (e.br_type != BR_NORMAL || c[1]);
        p.scnt      = c;
        p.history   = h;
        return p;
    endfunction

    function automatic correct_info_t make_rec(input logic [31:0] pc, input br_type_e t,
                                               input logic [31:0] tgt, input logic taken,
                                               input logic tmiss, input logic gmiss,
                                               input logic [4:0] hist, input logic [1:0] scnt);
        correct_info_t r;
        r.update      = 1'b1;
        r.pc          = pc;
        r.is_branch   = 1'b1;
        r.br_type     = t;
        r.target_pc   = tgt;
        r.taken       = taken;
        r.type_miss   = tmiss;
        r.target_miss = gmiss;
        r.history     = hist;
        r.scnt        = scnt;
        return r;
    endfunction

    task automatic add_row(input logic fl, input logic [31:0] addr, input logic rdy,
                           input correct_info_t c0, input correct_info_t c1);
        row_t r;
        r       = '0;
        r.flush = fl;
        r.redir = addr;
        r.ready = rdy;
        r.ci0   = c0;
        r.ci1   = c1;
        if (nrows < NROWS) begin
            rows[nrows] = r;
            nrows++;
        end
    endtask

    // model takes the edge that samples row r
    task automatic model_step(input row_t r);
        correct_info_t rec;
        logic          s;
        logic [5:0]    i;
        rec = r.ci0.update ? r.ci0 : r.ci1;
        if (r.flush) begin
            m_pc = r.redir;
        end else if (r.ready) begin
            m_pc = r.exp_next;
        end
        if (rec.update) begin
            s = rec.pc[2];
            i = ref_idx(rec.pc);
            if (rec.type_miss || rec.target_miss) begin
                m_btb[s][i] = {rec.is_branch, ref_tag(rec.pc), rec.br_type, rec.target_pc};
            end
            m_bht[s][i] = rec.type_miss ? {4'b0000, rec.taken} : {rec.history[3:0], rec.taken};
            m_pht[s][{rec.history, rec.pc[5:3]}] = ref_count(rec.scnt, rec.taken);
            if (rec.br_type == BR_CALL) begin
                m_ras.push_back(rec.pc + 32'd4);
                if (m_ras.size() > BPU_RAS_DEPTH) begin
                    void'(m_ras.pop_front());   // oldest overwritten
                end
            end else if (rec.br_type == BR_RET && m_ras.size() > 0) begin
                void'(m_ras.pop_back());
            end
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_mask(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_pred(input string name, input slot_predict_t got,
                              input slot_predict_t exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic build_rows();
        correct_info_t idle;
        logic [31:0]   a;
        idle = '0;
        repeat (4) add_row(1'b0, 32'd0, 1'b1, idle, idle);          // sequential fetch
        repeat (2) add_row(1'b0, 32'd0, 1'b0, idle, idle);          // stall holds
        add_row(1'b1, 32'h1c00_1004, 1'b1, idle, idle);             // enter at slot 1
        add_row(1'b1, 32'h1c00_2004, 1'b0, idle, idle);             // flush beats stall
        add_row(1'b0, 32'd0, 1'b0, idle, idle);
        add_row(1'b0, 32'd0, 1'b1, idle, idle);
        // jump learning in slot 1, then a tag alias
        add_row(1'b0, 32'd0, 1'b1, make_rec(JMP_PC, BR_JUMP, JMP_TGT, 1, 0, 1, 0, 0), idle);
        add_row(1'b1, JMP_PC, 1'b1, idle, idle);
        add_row(1'b0, 32'd0, 1'b1, idle, idle);
        add_row(1'b1, JMP_PC ^ 32'h0001_0000, 1'b1, idle, idle);
        add_row(1'b0, 32'd0, 1'b1, idle, idle);
        // conditional counter training in slot 0
        add_row(1'b0, 32'd0, 1'b1, make_rec(CND_PC, BR_NORMAL, CND_TGT, 1, 1, 0, 0, 0), idle);
        add_row(1'b1, CND_PC, 1'b1, idle, idle);
        add_row(1'b0, 32'd0, 1'b1,
                make_rec(CND_PC, BR_NORMAL, CND_TGT, 1, 0, 0, 5'b11111, 2'd2), idle);
        add_row(1'b1, CND_PC, 1'b1, idle, idle);
        add_row(1'b0, 32'd0, 1'b1, idle, idle);
        add_row(1'b0, 32'd0, 1'b1,
                make_rec(CND_PC, BR_NORMAL, CND_TGT, 0, 1, 0, 5'b11111, 2'd3), idle);
        add_row(1'b1, CND_PC, 1'b1, idle, idle);
        // return stack pops on empty, pushes, predicts a return and pops back to empty
        add_row(1'b0, 32'd0, 1'b1, make_rec(RET_PC, BR_RET, 32'd0, 1, 1, 0, 0, 0), idle);
        add_row(1'b0, 32'd0, 1'b1, make_rec(CALL_PC, BR_CALL, RET_PC, 1, 1, 0, 0, 0), idle);
        add_row(1'b1, RET_PC, 1'b1, idle, idle);
        add_row(1'b0, 32'd0, 1'b0, idle, idle);
        add_row(1'b0, 32'd0, 1'b1, make_rec(RET_PC, BR_RET, 32'd0, 1, 0, 0, 0, 0), idle);
        add_row(1'b1, RET_PC, 1'b1, idle, idle);
        add_row(1'b1, 32'h1c00_0100, 1'b1, idle, idle);
        // both records flagged, only record 0 trains
        add_row(1'b0, 32'd0, 1'b1, make_rec(SEL_PC, BR_JUMP, 32'h1c00_d000, 1, 0, 1, 0, 0),
                make_rec(SEL_PC + 32'd4, BR_JUMP, 32'h1c00_e000, 1, 0, 1, 0, 0));
        add_row(1'b1, SEL_PC, 1'b1, idle, idle);
        add_row(1'b0, 32'd0, 1'b1, idle, idle);
        while (nrows < NROWS) begin
            a = lcg_next();
            add_row(a[0], {12'h1c0, a[19:2], 2'b00}, a[1], idle, idle);   // filler
        end
    endtask

    initial begin
        slot_predict_t p0;
        slot_predict_t p1;
        logic          slot0_br;
        rst_n           = 1'b0;
        flush_i         = 1'b0;
        ready_i         = 1'b0;
        redir_addr_i    = 32'd0;
        correct_infos_i = '0;
        lcg_state       = LCG_SEED;
        nrows           = 0;
        m_pc            = BPU_INIT_PC;
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 64; i++) begin
                m_btb[s][i] = '0;
                m_bht[s][i] = '0;
            end
            for (int i = 0; i < 256; i++) begin
                m_pht[s][i] = '0;
            end
        end
        build_rows();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int k = 0; k < NROWS; k++) begin
            @(posedge clk);
            flush_i            <= rows[k].flush;
            redir_addr_i       <= rows[k].redir;
            ready_i            <= rows[k].ready;
            correct_infos_i[0] <= rows[k].ci0;
            correct_infos_i[1] <= rows[k].ci1;
            @(negedge clk);   // outputs settled from the last edge
            p0       = ref_predict(0);
            p1       = ref_predict(1);
            slot0_br = !m_pc[2] && p0.taken;
            rows[k].exp_pc    = m_pc;
            rows[k].exp_mask  = {!slot0_br, !m_pc[2]};
            rows[k].exp_pred0 = p0;
            rows[k].exp_pred1 = p1;
            // next pc is seen as the fetch pc of the following row
            if (slot0_br) begin
                rows[k].exp_next = p0.target_pc;
            end else if (p1.taken) begin
                rows[k].exp_next = p1.target_pc;
            end else begin
                rows[k].exp_next = {m_pc[31:3] + 29'd1, 3'b000};
            end
            check_pc("fetch_o.pc", fetch_o.pc, rows[k].exp_pc);
            check_mask("fetch_o.mask", fetch_o.mask, rows[k].exp_mask);
            check_pred("fetch_o.pred[0]", fetch_o.pred[0], rows[k].exp_pred0);
            check_pred("fetch_o.pred[1]", fetch_o.pred[1], rows[k].exp_pred1);
            model_step(rows[k]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the bpu testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module bpu_tb -o bpu_tb_sim

# a failing run ends in $fatal, which gives a nonzero exit status
./obj_dir/bpu_tb_sim

// ==== src/bpu.sv ====
`timescale 1ns/1ps

module bpu
    import bpu_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    input  logic                flush_i,        // one-cycle redirect from the back end
    input  logic                ready_i,        // low stalls fetch
    input  logic [31:0]         redir_addr_i,

    input  correct_info_t [1:0] correct_infos_i,
    output fetch_pkg_t          fetch_o
);

    slot_update_t  [BPU_SLOT_NUM-1:0] slot_upd;
    slot_predict_t [BPU_SLOT_NUM-1:0] slot_pred;
    logic [31:0]                      fetch_pc;
    logic                             ras_push;
    logic                             ras_pop;
    logic [31:0]                      ras_push_addr;
    logic [31:0]                      ras_top;

    // training side
    bpu_update_select u_update_select (
        .correct_infos_i (correct_infos_i),
        .slot_upd_o      (slot_upd),
        .ras_push_o      (ras_push),
        .ras_pop_o       (ras_pop),
        .ras_push_addr_o (ras_push_addr)
    );

    // one predictor per instruction slot
    for (genvar i = 0; i < BPU_SLOT_NUM; i++) begin : g_slot
        bpu_slot u_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .fetch_pc_i (fetch_pc),
            .upd_i      (slot_upd[i]),
            .pred_o     (slot_pred[i])
        );
    end

    bpu_ras u_ras (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_addr_i (ras_push_addr),
        .top_o       (ras_top)
    );

    // owns the fetch pc and closes the loop back to the slots
    bpu_fetch_select u_fetch_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .ready_i      (ready_i),
        .redir_addr_i (redir_addr_i),
        .slot_pred_i  (slot_pred),
        .ras_top_i    (ras_top),
        .fetch_pc_o   (fetch_pc),
        .fetch_o      (fetch_o)
    );

endmodule

// ==== src/bpu_fetch_select.sv ====
`timescale 1ns/1ps

module bpu_fetch_select
    import bpu_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              flush_i,
    input  logic                              ready_i,
    input  logic [31:0]                       redir_addr_i,
    input  slot_predict_t [BPU_SLOT_NUM-1:0]  slot_pred_i,
    input  logic [31:0]                       ras_top_i,
    output logic [31:0]                       fetch_pc_o,
    output fetch_pkg_t                        fetch_o
);

    logic [31:0]                      pc_q;
    logic [31:0]                      pc_next;
    logic [31:0]                      pc_seq;     // next aligned pair
    logic                             slot0_act;  // slot 0 lies on the fetch path
    logic                             slot0_br;   // fetch leaves from slot 0
    logic [1:0]                       mask;
    slot_predict_t [BPU_SLOT_NUM-1:0] pred;       // predictions after return fixup

    // fetch address register where flush beats stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= BPU_INIT_PC;
        end else if (flush_i) begin
            pc_q <= redir_addr_i;
        end else if (ready_i) begin
            pc_q <= pc_next;
        end
    end

    // returns take their target from the stack
    always_comb begin
        for (int i = 0; i < BPU_SLOT_NUM; i++) begin
            pred[i] = slot_pred_i[i];
            if (slot_pred_i[i].hit && slot_pred_i[i].br_type == BR_RET) begin
                pred[i].target_pc = ras_top_i;
            end
        end
    end

    assign pc_seq    = {pc_q[31:3] + 29'd1, 3'b000};
    assign slot0_act = ~pc_q[2];                   // entered at bit 2 set skips slot 0
    assign slot0_br  = slot0_act & pred[0].taken;

    // slot 1 is dropped behind a taken slot 0
    assign mask = {~slot0_br, slot0_act};

    always_comb begin
        pc_next = pc_seq;
        if (slot0_br) begin
            pc_next = pred[0].target_pc;
        end else if (pred[1].taken) begin
            pc_next = pred[1].target_pc;
        end
    end

    assign fetch_pc_o   = pc_q;
    assign fetch_o.pc   = pc_q;
    assign fetch_o.mask = mask;
    assign fetch_o.pred = pred;

endmodule

// ==== src/bpu_pkg.sv ====
package bpu_pkg;

    localparam logic [31:0] BPU_INIT_PC = 32'h1c00_0000;     // fetch address out of reset
    localparam int BPU_SLOT_NUM    = 2;                        // two 4-byte slots per fetch
    localparam int BPU_BTB_IDX_LEN = 6;
    localparam int BPU_BTB_DEPTH   = 1 << BPU_BTB_IDX_LEN;     // 64 entries per slot
    localparam int BPU_TAG_LEN     = 8;
    localparam int BPU_HISTORY_LEN = 5;                        // local history bits
    localparam int BPU_PHT_PC_LEN  = 3;
    localparam int BPU_PHT_IDX_LEN = BPU_HISTORY_LEN + BPU_PHT_PC_LEN;
    localparam int BPU_PHT_DEPTH   = 1 << BPU_PHT_IDX_LEN;     // 256 counters per slot
    localparam int BPU_RAS_DEPTH   = 8;
    localparam int BPU_RAS_PTR_LEN = $clog2(BPU_RAS_DEPTH);

    typedef enum logic [1:0] {
        BR_NORMAL = 2'd0,   // conditional
        BR_JUMP   = 2'd1,   // unconditional direct
        BR_CALL   = 2'd2,
        BR_RET    = 2'd3
    } br_type_e;

    typedef struct packed {
        logic                   is_branch;  // doubles as entry valid
        logic [BPU_TAG_LEN-1:0] tag;
        br_type_e               br_type;
        logic [31:0]            target_pc;
    } bpu_btb_entry_t;

    // one record from the back end
    typedef struct packed {
        logic                       update;
        logic [31:0]                pc;
        logic                       is_branch;
        br_type_e                   br_type;
        logic [31:0]                target_pc;
        logic                       taken;
        logic                       type_miss;
        logic                       target_miss;
        logic [BPU_HISTORY_LEN-1:0] history;     // history seen at predict time
        logic [1:0]                 scnt;        // counter seen at predict time
    } correct_info_t;

    typedef struct packed {
        logic                       btb_we;
        logic                       bht_we;
        logic                       pht_we;
        logic [BPU_BTB_IDX_LEN-1:0] idx;         // shared by target and history tables
        logic [BPU_PHT_IDX_LEN-1:0] pht_idx;
        bpu_btb_entry_t             btb_wdata;
        logic [BPU_HISTORY_LEN-1:0] history_new;
        logic [1:0]                 scnt_new;
    } slot_update_t;

    typedef struct packed {
        logic                       hit;
        logic                       is_branch;
        br_type_e                   br_type;
        logic [31:0]                target_pc;
        logic                       taken;
        logic [1:0]                 scnt;
        logic [BPU_HISTORY_LEN-1:0] history;
    } slot_predict_t;

    typedef struct packed {
        logic [31:0]                        pc;
        logic [1:0]                         mask;   // bit i set, slot i is fetched
        slot_predict_t [BPU_SLOT_NUM-1:0]   pred;
    } fetch_pkg_t;

    // table index folds two address fields together
    function automatic logic [BPU_BTB_IDX_LEN-1:0] bpu_idx(input logic [31:0] pc);
        return pc[14:9] ^ pc[8:3];
    endfunction

    function automatic logic [BPU_TAG_LEN-1:0] bpu_tag(input logic [31:0] pc);
        return pc[BPU_TAG_LEN+11:12];
    endfunction

    // history on top, low address bits below
    function automatic logic [BPU_PHT_IDX_LEN-1:0] bpu_pht_idx(
        input logic [BPU_HISTORY_LEN-1:0] history,
        input logic [31:0]                pc
    );
        return {history, pc[BPU_PHT_PC_LEN+2:3]};
    endfunction

endpackage

// ==== src/bpu_ras.sv ====
`timescale 1ns/1ps

module bpu_ras
    import bpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push_i,
    input  logic        pop_i,
    input  logic [31:0] push_addr_i,
    output logic [31:0] top_o
);

    logic [31:0]                stack_q [BPU_RAS_DEPTH];
    logic [BPU_RAS_PTR_LEN-1:0] top_ptr_q;   // newest entry
    logic [BPU_RAS_PTR_LEN-1:0] w_ptr_q;     // next free slot
    logic [BPU_RAS_PTR_LEN:0]   cnt_q;       // live entries with msb set when full
    logic                       empty;

    assign empty = (cnt_q == '0);
    assign top_o = empty ? 32'd0 : stack_q[top_ptr_q];

    // stack storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[w_ptr_q] <= push_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr_q <= '1;   // one below the write pointer
            w_ptr_q   <= '0;
            cnt_q     <= '0;
        end else if (push_i) begin
            top_ptr_q <= w_ptr_q;
            w_ptr_q   <= w_ptr_q + 1'b1;   // wraps and drops the oldest entry
            if (!cnt_q[BPU_RAS_PTR_LEN]) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (pop_i && !empty) begin
            w_ptr_q   <= top_ptr_q;
            top_ptr_q <= top_ptr_q - 1'b1;
            cnt_q     <= cnt_q - 1'b1;
        end
    end

endmodule

// ==== src/bpu_slot.sv ====
`timescale 1ns/1ps

module bpu_slot
    import bpu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic [31:0]   fetch_pc_i,
    input  slot_update_t  upd_i,
    output slot_predict_t pred_o
);

    // tables are plain flop arrays
    bpu_btb_entry_t             btb_q [BPU_BTB_DEPTH];
    logic [BPU_HISTORY_LEN-1:0] bht_q [BPU_BTB_DEPTH];
    logic [1:0]                 pht_q [BPU_PHT_DEPTH];

    logic [BPU_BTB_IDX_LEN-1:0] rd_idx;
    logic [BPU_TAG_LEN-1:0]     rd_tag;
    logic [BPU_PHT_IDX_LEN-1:0] pht_ridx;
    bpu_btb_entry_t             btb_rd;
    logic [BPU_HISTORY_LEN-1:0] bht_rd;
    logic [1:0]                 pht_rd;
    logic                       hit;
    logic                       taken;

    // lookup happens within the fetch cycle
    assign rd_idx   = bpu_idx(fetch_pc_i);
    assign rd_tag   = bpu_tag(fetch_pc_i);
    assign btb_rd   = btb_q[rd_idx];
    assign bht_rd   = bht_q[rd_idx];               // same index as the target buffer
    assign pht_ridx = bpu_pht_idx(bht_rd, fetch_pc_i);
    assign pht_rd   = pht_q[pht_ridx];             // chained behind the history read

    assign hit = btb_rd.is_branch & (btb_rd.tag == rd_tag);

    // anything but a conditional is always taken
    assign taken = hit & ((btb_rd.br_type != BR_NORMAL) | pht_rd[1]);

    assign pred_o.hit       = hit;
    assign pred_o.is_branch = btb_rd.is_branch;
    assign pred_o.br_type   = btb_rd.br_type;
    assign pred_o.target_pc = btb_rd.target_pc;    // return target swapped in downstream
    assign pred_o.taken     = taken;
    assign pred_o.scnt      = pht_rd;
    assign pred_o.history   = bht_rd;

    // target buffer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BPU_BTB_DEPTH; i++) begin
                btb_q[i] <= '0;   // no hits out of reset
            end
        end else if (upd_i.btb_we) begin
            btb_q[upd_i.idx] <= upd_i.btb_wdata;
        end
    end

    // local history
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BPU_BTB_DEPTH; i++) begin
                bht_q[i] <= '0;
            end
        end else if (upd_i.bht_we) begin
            bht_q[upd_i.idx] <= upd_i.history_new;
        end
    end

    // 2-bit counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BPU_PHT_DEPTH; i++) begin
                pht_q[i] <= 2'b00;   // strongly not taken
            end
        end else if (upd_i.pht_we) begin
            pht_q[upd_i.pht_idx] <= upd_i.scnt_new;
        end
    end

endmodule

// ==== src/bpu_update_select.sv ====
`timescale 1ns/1ps

module bpu_update_select
    import bpu_pkg::*;
(
    input  correct_info_t [1:0]               correct_infos_i,
    output slot_update_t  [BPU_SLOT_NUM-1:0]  slot_upd_o,
    output logic                              ras_push_o,
    output logic                              ras_pop_o,
    output logic [31:0]                       ras_push_addr_o
);

    correct_info_t rec;        // the record that trains this cycle
    slot_update_t  upd;        // write request before slot routing
    logic          rec_slot;   // pc bit 2 picks the slot

    // saturating step of a 2-bit counter
    function automatic logic [1:0] step_scnt(input logic [1:0] scnt, input logic taken);
        logic [1:0] nxt;
        nxt = scnt;
        if (taken && scnt != 2'b11) begin
            nxt = scnt + 2'd1;
        end else if (!taken && scnt != 2'b00) begin
            nxt = scnt - 2'd1;
        end
        return nxt;
    endfunction

    // first flagged record wins
    assign rec      = correct_infos_i[0].update ? correct_infos_i[0] : correct_infos_i[1];
    assign rec_slot = rec.pc[2];

    assign upd.btb_we  = rec.update & (rec.type_miss | rec.target_miss);
    assign upd.bht_we  = rec.update;
    assign upd.pht_we  = rec.update;
    assign upd.idx     = bpu_idx(rec.pc);
    assign upd.pht_idx = bpu_pht_idx(rec.history, rec.pc);   // index the counter was read at

    assign upd.btb_wdata.is_branch = rec.is_branch;
    assign upd.btb_wdata.tag       = bpu_tag(rec.pc);
    assign upd.btb_wdata.br_type   = rec.br_type;
    assign upd.btb_wdata.target_pc = rec.target_pc;

    // wrong type means the old history belonged to something else so it restarts
    assign upd.history_new = rec.type_miss ? {{(BPU_HISTORY_LEN-1){1'b0}}, rec.taken}
                                           : {rec.history[BPU_HISTORY_LEN-2:0], rec.taken};
    assign upd.scnt_new    = step_scnt(rec.scnt, rec.taken);

    always_comb begin
        for (int i = 0; i < BPU_SLOT_NUM; i++) begin
            slot_upd_o[i]        = upd;
            // enables only reach the addressed slot
            slot_upd_o[i].btb_we = upd.btb_we & (rec_slot == 1'(i));
            slot_upd_o[i].bht_we = upd.bht_we & (rec_slot == 1'(i));
            slot_upd_o[i].pht_we = upd.pht_we & (rec_slot == 1'(i));
        end
    end

    // return stack follows the resolved calls and returns
    assign ras_push_o      = rec.update & (rec.br_type == BR_CALL);
    assign ras_pop_o       = rec.update & (rec.br_type == BR_RET);
    assign ras_push_addr_o = rec.pc + 32'd4;   // link address

endmodule

// ==== tb.f ====
src/bpu_pkg.sv
src/bpu_update_select.sv
src/bpu_slot.sv
src/bpu_ras.sv
src/bpu_fetch_select.sv
src/bpu.sv
bench/bpu_tb.sv
